//--- hw/decoder_config.svh
`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// Program memory word
`define INSTR_WIDTH 16

// IALU operand word
`define IALU_WORD_WIDTH 16

// Register file index, one of 16 registers
`define REG_IDX_WIDTH 4

// Root opcode in word bits 3:0
`define OPCODE_WIDTH 4

// Width of every function field
`define FUNC_WIDTH 4

// Short immediate in word bits 15:12
`define IMMA_WIDTH 4

`endif

//--- hw/decoder_pkg.sv
`default_nettype none

`include "decoder_config.svh"

package decoder_pkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        NOP    = 0,
        U_TYPE = 1,
        J_TYPE = 2,
        S_TYPE = 3,
        LH     = 4,
        LHO    = 5,
        ADD    = 6,
        SUB    = 7
    } opcode_e;

    // S-type function, word bits 7:4
    typedef enum logic [`FUNC_WIDTH-1:0] {
        SH  = 4,
        SHO = 5
    } s_func_e;

    // U-type function, word bits 11:8
    typedef enum logic [`FUNC_WIDTH-1:0] {
        LI  = 3,
        LIL = 4
    } u_func_e;

    typedef struct packed {
        logic ialu_add;
        logic neg_src1;
        logic neg_src2;
        logic load_dmem;
        logic store_dmem;
        logic write_res_to_reg;
        logic write_src2_to_res;
    } ctrl_t;

    typedef enum logic [2:0] {
        ZERO      = 0,
        REG_A     = 1,
        REG_B     = 2,
        IMM_SHORT = 3,
        IMM_WORD  = 4
    } opnd_sel_e;

    typedef struct packed {
        logic [`INSTR_WIDTH-1:0] first_word;
        logic [`INSTR_WIDTH-1:0] cur_word;
        logic                    flushed;
    } seq_word_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        opnd_sel_e                 sel1;
        opnd_sel_e                 sel2;
        opnd_sel_e                 sel3;
        logic [`REG_IDX_WIDTH-1:0] res_reg_idx;
    } decode_t;

    typedef struct packed {
        ctrl_t                       ctrl;
        logic [`IALU_WORD_WIDTH-1:0] src1;
        logic [`IALU_WORD_WIDTH-1:0] src2;
        logic [`IALU_WORD_WIDTH-1:0] src3;
        logic [`REG_IDX_WIDTH-1:0]   res_reg_idx;
    } issue_t;

    // LI, LHO and SHO carry a second word
    function automatic logic is_two_word(input logic [`INSTR_WIDTH-1:0] word);
        logic [`OPCODE_WIDTH-1:0] opc;
        opc = word[`OPCODE_WIDTH-1:0];
        return (opc == LHO)
            || (opc == U_TYPE && word[11:8] == LI)
            || (opc == S_TYPE && word[7:4] == SHO);
    endfunction

endpackage

`default_nettype wire

//--- hw/word_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module word_sequencer
    import decoder_pkg::*;
(
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic [`INSTR_WIDTH-1:0]   instr,
    input  wire logic                      flush,
    output seq_word_t                      seq,
    output logic      [`REG_IDX_WIDTH-1:0] src1_reg_idx,
    output logic      [`REG_IDX_WIDTH-1:0] src2_reg_idx
);

    logic [`INSTR_WIDTH-1:0] cur_word_q;
    logic [`INSTR_WIDTH-1:0] prev_word_q;   // Word sampled one edge earlier
    logic                    flush_q;
    logic                    second_q;      // Current word is a second word
    logic                    second_d;
    logic [`INSTR_WIDTH-1:0] first_word;

    // Sample the incoming word every cycle, no stall
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cur_word_q  <= '0;
            prev_word_q <= '0;
            flush_q     <= 1'b0;
        end else begin
            cur_word_q  <= instr;
            prev_word_q <= cur_word_q;
            flush_q     <= flush;
        end
    end

    // A first word that opens a pair, and was not flushed, moves us to phase two.
    // A second word or a flush always brings us back to phase one.
    assign second_d = !second_q && !flush_q && is_two_word(cur_word_q);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            second_q <= 1'b0;
        end else begin
            second_q <= second_d;
        end
    end

    assign first_word = second_q ? prev_word_q : cur_word_q;

    assign seq.first_word = first_word;
    assign seq.cur_word   = cur_word_q;
    assign seq.flushed    = flush_q;

    // Register file read indices
    assign src1_reg_idx = first_word[11:8];
    assign src2_reg_idx = first_word[15:12];

endmodule

`default_nettype wire

//--- hw/control_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module control_decoder
    import decoder_pkg::*;
(
    input  wire seq_word_t seq,
    output decode_t        dec
);

    opcode_e opcode;
    s_func_e s_func;
    u_func_e u_func;
    logic    first_of_pair;

    assign opcode = opcode_e'(seq.first_word[`OPCODE_WIDTH-1:0]);
    assign s_func = s_func_e'(seq.first_word[7:4]);
    assign u_func = u_func_e'(seq.first_word[11:8]);

    // Phase one of a pair shows the same word on both slots
    assign first_of_pair = is_two_word(seq.first_word) && (seq.first_word == seq.cur_word);

    always_comb begin
        dec = '0;

        if (!seq.flushed && !first_of_pair) begin
            case (opcode)
                ADD: begin
                    dec.ctrl.ialu_add         = 1'b1;
                    dec.ctrl.write_res_to_reg = 1'b1;
                    dec.sel1                  = REG_A;
                    dec.sel2                  = REG_B;
                end

                SUB: begin
                    dec.ctrl.ialu_add         = 1'b1;
                    dec.ctrl.neg_src2         = 1'b1;   // a + (-b)
                    dec.ctrl.write_res_to_reg = 1'b1;
                    dec.sel1                  = REG_A;
                    dec.sel2                  = REG_B;
                end

                U_TYPE: begin
                    case (u_func)
                        LIL: begin
                            dec.ctrl.write_res_to_reg  = 1'b1;
                            dec.ctrl.write_src2_to_res = 1'b1;
                            dec.sel2                   = IMM_SHORT;
                        end
                        LI: begin
                            dec.ctrl.write_res_to_reg  = 1'b1;
                            dec.ctrl.write_src2_to_res = 1'b1;
                            dec.sel2                   = IMM_WORD;
                        end
                        default: ;
                    endcase
                end

                LH: begin
                    dec.ctrl.load_dmem         = 1'b1;
                    dec.ctrl.write_res_to_reg  = 1'b1;
                    dec.ctrl.write_src2_to_res = 1'b1;
                    dec.sel2                   = REG_A;   // Address rides on src2
                end

                LHO: begin
                    dec.ctrl.ialu_add         = 1'b1;
                    dec.ctrl.load_dmem        = 1'b1;
                    dec.ctrl.write_res_to_reg = 1'b1;
                    dec.sel1                  = REG_A;
                    dec.sel2                  = IMM_WORD;
                end

                S_TYPE: begin
                    case (s_func)
                        SH: begin
                            dec.ctrl.store_dmem        = 1'b1;
                            dec.ctrl.write_src2_to_res = 1'b1;
                            dec.sel2                   = REG_B;   // Address
                            dec.sel3                   = REG_A;   // Store data
                        end
                        SHO: begin
                            dec.ctrl.ialu_add   = 1'b1;
                            dec.ctrl.store_dmem = 1'b1;
                            dec.sel1            = IMM_WORD;       // Base
                            dec.sel2            = REG_B;
                            dec.sel3            = REG_A;
                        end
                        default: ;   // Branches decode as NOP
                    endcase
                end

                default: ;   // NOP, jumps and unknown opcodes
            endcase
        end

        // Destination only matters when a result is written back
        if (dec.ctrl.write_res_to_reg) begin
            dec.res_reg_idx = seq.first_word[7:4];
        end
    end

endmodule

`default_nettype wire

//--- hw/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module issue_stage
    import decoder_pkg::*;
(
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire decode_t                     dec,
    input  wire seq_word_t                   seq,
    input  wire logic [`IALU_WORD_WIDTH-1:0] src1,
    input  wire logic [`IALU_WORD_WIDTH-1:0] src2,
    output issue_t                           issue
);

    logic [`IALU_WORD_WIDTH-1:0] imm_short;
    logic [`IALU_WORD_WIDTH-1:0] imm_word;
    issue_t                      issue_d;

    function automatic logic [`IALU_WORD_WIDTH-1:0] pick(
        input opnd_sel_e                   sel,
        input logic [`IALU_WORD_WIDTH-1:0] reg_a,
        input logic [`IALU_WORD_WIDTH-1:0] reg_b,
        input logic [`IALU_WORD_WIDTH-1:0] short_imm,
        input logic [`IALU_WORD_WIDTH-1:0] word_imm
    );
        case (sel)
            REG_A:     return reg_a;
            REG_B:     return reg_b;
            IMM_SHORT: return short_imm;
            IMM_WORD:  return word_imm;
            default:   return '0;
        endcase
    endfunction

    // LIL immediate is zero extended
    assign imm_short = {{(`IALU_WORD_WIDTH-`IMMA_WIDTH){1'b0}},
                        seq.first_word[15:12]};

    // Second word of a pair
    assign imm_word = seq.cur_word;

    always_comb begin
        issue_d.ctrl        = dec.ctrl;
        issue_d.src1        = pick(dec.sel1, src1, src2, imm_short, imm_word);
        issue_d.src2        = pick(dec.sel2, src1, src2, imm_short, imm_word);
        issue_d.src3        = pick(dec.sel3, src1, src2, imm_short, imm_word);
        issue_d.res_reg_idx = dec.res_reg_idx;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            issue <= '0;
        end else begin
            issue <= issue_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/instr_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module instr_decoder_top
    import decoder_pkg::*;
(
    input  wire logic [`INSTR_WIDTH-1:0]     instr,
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        flush,
    input  wire logic [`IALU_WORD_WIDTH-1:0] src1,     // Register file read data
    input  wire logic [`IALU_WORD_WIDTH-1:0] src2,
    output logic      [`REG_IDX_WIDTH-1:0]   src1_reg_idx,
    output logic      [`REG_IDX_WIDTH-1:0]   src2_reg_idx,
    output issue_t                           issue
);

    seq_word_t seq;
    decode_t   dec;

    word_sequencer u_word_sequencer (
        .clock        (clock),
        .reset        (reset),
        .instr        (instr),
        .flush        (flush),
        .seq          (seq),
        .src1_reg_idx (src1_reg_idx),
        .src2_reg_idx (src2_reg_idx)
    );

    control_decoder u_control_decoder (
        .seq (seq),
        .dec (dec)
    );

    issue_stage u_issue_stage (
        .clock (clock),
        .reset (reset),
        .dec   (dec),
        .seq   (seq),
        .src1  (src1),
        .src2  (src2),
        .issue (issue)
    );

endmodule

`default_nettype wire

//--- sim/decoder_sva.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_sva
    import decoder_pkg::*;
(
    input wire logic   clock,
    input wire logic   reset,
    input wire issue_t issue
);

    // First edge after reset release still shows an empty bundle
    reset_clears_issue: assert property (@(posedge clock) $fell(reset) |-> issue == '0)
        else $error("issue bundle not zero after reset");

    load_store_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(issue.ctrl.load_dmem && issue.ctrl.store_dmem))
        else $error("load_dmem and store_dmem set together");

    move_without_add: assert property (@(posedge clock) disable iff (reset)
        issue.ctrl.write_src2_to_res |-> !issue.ctrl.ialu_add)
        else $error("write_src2_to_res set together with ialu_add");

    negate_needs_add: assert property (@(posedge clock) disable iff (reset)
        issue.ctrl.neg_src2 |-> issue.ctrl.ialu_add)   // Subtract is an add of -b
        else $error("neg_src2 set without ialu_add");

endmodule

bind issue_stage decoder_sva u_decoder_sva (
    .clock (clock),
    .reset (reset),
    .issue (issue)
);

`default_nettype wire

//--- sim/decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "decoder_config.svh"

module decoder_tb
    import decoder_pkg::*;
();

    localparam int EDGE_TIMEOUT_NS = 100;
    localparam int DRIVE_DELAY_NS  = 2;

    logic                        clock;
    logic                        reset;
    logic [`INSTR_WIDTH-1:0]     instr;
    logic                        flush;
    logic [`IALU_WORD_WIDTH-1:0] src1;
    logic [`IALU_WORD_WIDTH-1:0] src2;
    logic [`REG_IDX_WIDTH-1:0]   src1_reg_idx;
    logic [`REG_IDX_WIDTH-1:0]   src2_reg_idx;
    issue_t                      issue;

    logic [`IALU_WORD_WIDTH-1:0] regfile [0:15];
    logic [15:0]                 lfsr_state;
    int                          edge_count = 0;
    time                         edge_time = 0;
    logic                        timed_out = 1'b0;
    int                          test_count = 0;
    int                          check_count = 0;
    int                          error_count = 0;
    int                          errors_before;
    issue_t                      exp_q[$];   // One bundle per word in flight

    instr_decoder_top u_dut (
        .instr        (instr),
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .src1         (src1),
        .src2         (src2),
        .src1_reg_idx (src1_reg_idx),
        .src2_reg_idx (src2_reg_idx),
        .issue        (issue)
    );

    // Register file answers in the same cycle
    assign src1 = regfile[src1_reg_idx];
    assign src2 = regfile[src2_reg_idx];

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        edge_count <= edge_count + 1;
        edge_time  <= $time;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [3:0] rand_nibble();
        logic [3:0] val;
        val = '0;
        for (int i = 0; i < 4; i++) begin
            val = {val[2:0], lfsr_bit()};
        end
        return val;
    endfunction

    function automatic logic [15:0] rand_word();
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < 16; i++) begin
            val = {val[14:0], lfsr_bit()};
        end
        return val;
    endfunction

    function automatic logic [15:0] pack_word(input logic [3:0] hi, input logic [3:0] mid,
                                              input logic [3:0] low, input logic [3:0] op);
        return {hi, mid, low, op};
    endfunction

    // Second word that cannot be mistaken for its opener
    function automatic logic [15:0] pick_second_word(input logic [15:0] first);
        logic [15:0] w2;
        w2 = rand_word();
        if (w2 == first) begin
            w2 = w2 ^ 16'h0001;
        end
        return w2;
    endfunction

    // Expected issue bundle from the instruction table
    function automatic issue_t expect_bundle(input logic [15:0] first, input logic [15:0] second);
        issue_t      b;
        logic [15:0] reg_a;
        logic [15:0] reg_b;
        b     = '0;
        reg_a = regfile[first[11:8]];
        reg_b = regfile[first[15:12]];
        case (first[3:0])
            ADD, SUB: begin
                b.ctrl.ialu_add         = 1'b1;
                b.ctrl.neg_src2         = (first[3:0] == SUB);
                b.ctrl.write_res_to_reg = 1'b1;
                b.src1                  = reg_a;
                b.src2                  = reg_b;
            end
            U_TYPE: begin
                if (first[11:8] == LIL || first[11:8] == LI) begin
                    b.ctrl.write_res_to_reg  = 1'b1;
                    b.ctrl.write_src2_to_res = 1'b1;
                    b.src2 = (first[11:8] == LIL) ? {12'b0, first[15:12]} : second;
                end
            end
            LH: begin
                b.ctrl.load_dmem         = 1'b1;
                b.ctrl.write_res_to_reg  = 1'b1;
                b.ctrl.write_src2_to_res = 1'b1;
                b.src2                   = reg_a;
            end
            LHO: begin
                b.ctrl.ialu_add         = 1'b1;
                b.ctrl.load_dmem        = 1'b1;
                b.ctrl.write_res_to_reg = 1'b1;
                b.src1                  = reg_a;
                b.src2                  = second;
            end
            S_TYPE: begin
                if (first[7:4] == SH || first[7:4] == SHO) begin
                    b.ctrl.store_dmem        = 1'b1;
                    b.ctrl.ialu_add          = (first[7:4] == SHO);
                    b.ctrl.write_src2_to_res = (first[7:4] == SH);
                    b.src1                   = (first[7:4] == SHO) ? second : 16'h0000;
                    b.src2                   = reg_b;
                    b.src3                   = reg_a;   // Store data
                end
            end
            default: ;
        endcase
        if (b.ctrl.write_res_to_reg) begin
            b.res_reg_idx = first[7:4];
        end
        return b;
    endfunction

    // Returns a fixed delay after the next rising edge
    task automatic wait_edge();
        int start;
        int waited;
        start  = edge_count;
        waited = 0;
        while (edge_count == start && waited < EDGE_TIMEOUT_NS && !timed_out) begin
            #1;
            waited++;
        end
        if (edge_count == start) begin
            if (!timed_out) begin
                $display("Timeout at %0t: no rising clock edge within %0d ns", $time, waited);
            end
            timed_out = 1'b1;
        end else begin
            #(edge_time + DRIVE_DELAY_NS - $time);
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] exp_val,
                               input logic [15:0] act_val);
        check_count++;
        assert (act_val === exp_val)
        else begin
            $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                     $time, name, exp_val, act_val);
            error_count++;
        end
    endtask

    task automatic compare_issue(input issue_t expected);
        if (!timed_out) begin
            check_value("issue.ctrl", {9'b0, expected.ctrl}, {9'b0, issue.ctrl});
            check_value("issue.src1", expected.src1, issue.src1);
            check_value("issue.src2", expected.src2, issue.src2);
            check_value("issue.src3", expected.src3, issue.src3);
            // Empty bundles carry no destination either
            if (expected.ctrl.write_res_to_reg || expected.ctrl == '0) begin
                check_value("issue.res_reg_idx", {12'b0, expected.res_reg_idx},
                            {12'b0, issue.res_reg_idx});
            end
        end
    endtask

    // Bundle of the previous word is on issue one edge later
    task automatic send_word(input logic [15:0] word, input logic flush_bit,
                             input issue_t expected);
        instr = word;
        flush = flush_bit;
        exp_q.push_back(expected);
        wait_edge();
        if (exp_q.size() > 1) begin
            compare_issue(exp_q.pop_front());
        end
    endtask

    task automatic send_pair(input logic [15:0] first, input logic [15:0] w2);
        send_word(first, 1'b0, '0);
        send_word(w2, 1'b0, expect_bundle(first, w2));
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("%-12s finished, %0d mismatches", name, error_count - errors_before);
    endtask

    task automatic add_sub_test();
        logic [15:0] word;
        for (int i = 0; i < 8; i++) begin
            word = pack_word(rand_nibble(), rand_nibble(), rand_nibble(), (i % 2 == 0) ? ADD : SUB);
            send_word(word, 1'b0, expect_bundle(word, '0));
        end
        send_word('0, 1'b0, '0);
    endtask

    task automatic load_imm_test();
        logic [15:0] word;
        logic [15:0] w2;
        word = pack_word(4'hf, LIL, rand_nibble(), U_TYPE);   // Top bit set to expose sign extension
        send_word(word, 1'b0, expect_bundle(word, '0));
        word = pack_word(4'h5, LIL, rand_nibble(), U_TYPE);
        send_word(word, 1'b0, expect_bundle(word, '0));
        word = pack_word(rand_nibble(), LI, rand_nibble(), U_TYPE);
        w2   = pick_second_word(word) | 16'h8000;
        send_pair(word, (w2 == word) ? (w2 ^ 16'h0001) : w2);
        word = pack_word(rand_nibble(), LI, rand_nibble(), U_TYPE);
        send_pair(word, pick_second_word(word));
        send_word('0, 1'b0, '0);
    endtask

    task automatic load_half_test();
        logic [15:0] word;
        for (int i = 0; i < 2; i++) begin
            word = pack_word(rand_nibble(), rand_nibble(), rand_nibble(), LH);
            send_word(word, 1'b0, expect_bundle(word, '0));
            word = pack_word(rand_nibble(), rand_nibble(), rand_nibble(), LHO);
            send_pair(word, pick_second_word(word));
        end
        send_word('0, 1'b0, '0);
    endtask

    task automatic store_half_test();
        logic [15:0] word;
        for (int i = 0; i < 2; i++) begin
            word = pack_word(rand_nibble(), rand_nibble(), SH, S_TYPE);
            send_word(word, 1'b0, expect_bundle(word, '0));
            word = pack_word(rand_nibble(), rand_nibble(), SHO, S_TYPE);
            send_pair(word, pick_second_word(word));
        end
        send_word('0, 1'b0, '0);
    endtask

    task automatic flush_nop_test();
        logic [15:0] word;
        word = pack_word(rand_nibble(), rand_nibble(), rand_nibble(), ADD);
        send_word(word, 1'b1, '0);
        // Flushed second word aborts LI
        word = pack_word(rand_nibble(), LI, rand_nibble(), U_TYPE);
        send_word(word, 1'b0, '0);
        send_word(pick_second_word(word), 1'b1, '0);
        word = pack_word(rand_nibble(), rand_nibble(), rand_nibble(), ADD);
        send_word(word, 1'b0, expect_bundle(word, '0));
        // Flushed opener leaves the next word a first word
        send_word(pack_word(rand_nibble(), rand_nibble(), rand_nibble(), LHO), 1'b1, '0);
        word = pack_word(rand_nibble(), rand_nibble(), rand_nibble(), SUB);
        send_word(word, 1'b0, expect_bundle(word, '0));
        send_word(16'h0000, 1'b0, '0);
        send_word(pack_word(rand_nibble(), rand_nibble(), rand_nibble(), NOP), 1'b0, '0);
        send_word(pack_word(rand_nibble(), rand_nibble(), rand_nibble(), J_TYPE), 1'b0, '0);
        for (int f = 0; f < 4; f++) begin
            send_word(pack_word(rand_nibble(), rand_nibble(), f[3:0], S_TYPE), 1'b0, '0);
        end
        send_word(pack_word(rand_nibble(), 4'h0, rand_nibble(), U_TYPE), 1'b0, '0);
        send_word(pack_word(rand_nibble(), rand_nibble(), rand_nibble(), 4'h8), 1'b0, '0);
        send_word(pack_word(rand_nibble(), rand_nibble(), rand_nibble(), 4'hf), 1'b0, '0);
        send_word('0, 1'b0, '0);
    endtask

    initial begin
        reset      = 1'b1;
        instr      = '0;
        flush      = 1'b0;
        lfsr_state = 16'd17022;
        for (int i = 0; i < 16; i++) begin
            regfile[i] = rand_word();
        end
        for (int i = 0; i < 4; i++) begin
            wait_edge();
        end
        reset = 1'b0;

        errors_before = error_count;
        compare_issue('0);
        report_test("reset");
        errors_before = error_count;
        add_sub_test();
        report_test("add_sub");
        errors_before = error_count;
        load_imm_test();
        report_test("load_imm");
        errors_before = error_count;
        load_half_test();
        report_test("load_half");
        errors_before = error_count;
        store_half_test();
        report_test("store_half");
        errors_before = error_count;
        flush_nop_test();
        report_test("flush_nop");

        $display("Tests %0d, checks %0d, mismatches %0d, timeout %0d",
                 test_count, check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- instr_decoder.f
+incdir+hw
hw/decoder_pkg.sv
hw/word_sequencer.sv
hw/control_decoder.sv
hw/issue_stage.sv
hw/instr_decoder_top.sv
sim/decoder_sva.sv
sim/decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the decoder testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
    --timescale 1ns/1ps \
    --top-module decoder_tb \
    -Mdir obj_dir \
    -f instr_decoder.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vdecoder_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
